//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
rtl/core_pkg.sv
rtl/alu.sv
rtl/fetch.sv
rtl/dec.sv
rtl/dmem_ctrl.sv
rtl/mem_arbiter.sv
rtl/core.sv
bench/core_asserts.sv
bench/tb_core.sv

//--- bench/core_asserts.sv
/* memory bus protocol assertions bound into core, with a failure count */
`timescale 1ns/100ps

module core_asserts import core_pkg::*; (
	input logic  cpu_clk,
	input logic  arst_n,
	input logic  mem_access,
	input logic  mem_rd0_wr1,
	input addr_t mem_addr,
	input data_t mem_write_data,
	input logic  mem_ready,
	input logic  mem_read_data_valid
);

	logic        rd_out;     // high from read accept until its data returns
	int unsigned fails = 0;  // failed assertion count

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n)
			rd_out <= 1'b0;
		else if (mem_read_data_valid)
			rd_out <= 1'b0;
		else if (mem_access && mem_ready && !mem_rd0_wr1)
			rd_out <= 1'b1;
	end

	// stalled request stays put
	a_hold: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		mem_access && !mem_ready |=> mem_access && $stable(mem_addr) &&
			$stable(mem_rd0_wr1) && (!mem_rd0_wr1 || $stable(mem_write_data)))
		else begin
			fails = fails + 1;
			$error("memory request changed while stalled");
		end

	a_one_read: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		rd_out |-> !mem_access)
		else begin
			fails = fails + 1;
			$error("new access started while a read was outstanding");
		end

	a_valid: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		mem_read_data_valid |-> rd_out)
		else begin
			fails = fails + 1;
			$error("read data valid without an outstanding read");
		end

endmodule

bind core core_asserts u_asserts (
	.cpu_clk             (cpu_clk),
	.arst_n              (arst_n),
	.mem_access          (mem_access),
	.mem_rd0_wr1         (mem_rd0_wr1),
	.mem_addr            (mem_addr),
	.mem_write_data      (mem_write_data),
	.mem_ready           (mem_ready),
	.mem_read_data_valid (mem_read_data_valid)
);

//--- bench/tb_core.sv
/* core testbench with a bus memory model, optional stalls and read latency,
   directed program tests and write-log checks */
`timescale 1ns/100ps

module tb_core import core_pkg::*; ();

	localparam int    MEM_WORDS   = 1024;      // 4 KB indexed by addr[11:2]
	localparam addr_t BOOT        = 32'h0000_0100;
	localparam addr_t BOOT_ALT    = 32'h0000_0240;
	localparam int    CYCLE_LIMIT = 5 * 4000;  // five tests of well under 4000 cycles each

	logic  cpu_clk = 1'b0;
	logic  arst_n;
	addr_t boot_addr;
	logic  mem_access, mem_rd0_wr1;
	addr_t mem_addr;
	data_t mem_write_data;
	logic  mem_ready = 1'b1;
	data_t mem_read_data = '0;
	logic  mem_read_data_valid = 1'b0;

	data_t  image [0:MEM_WORDS-1];  // copied into mem while reset is low
	data_t  mem   [0:MEM_WORDS-1];
	addr_t  wr_addr_q [$];
	data_t  wr_data_q [$];
	addr_t  exp_addr [$];
	data_t  exp_data [$];
	addr_t  prog_pc;
	integer seed;
	bit     lat_en;
	logic   rd_busy;
	int     rd_wait;
	addr_t  rd_addr;
	logic   first_seen, first_wr;
	addr_t  first_addr;
	int     cycles = 0;

	core u_dut (
		.cpu_clk             (cpu_clk),
		.arst_n              (arst_n),
		.boot_addr           (boot_addr),
		.mem_access          (mem_access),
		.mem_rd0_wr1         (mem_rd0_wr1),
		.mem_addr            (mem_addr),
		.mem_write_data      (mem_write_data),
		.mem_ready           (mem_ready),
		.mem_read_data       (mem_read_data),
		.mem_read_data_valid (mem_read_data_valid)
	);

	always #50 cpu_clk = ~cpu_clk;

	// bus memory model with at most one read outstanding
	always @(posedge cpu_clk) begin
		if (!arst_n) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] = image[i];
			wr_addr_q.delete();
			wr_data_q.delete();
			rd_busy    = 1'b0;
			first_seen = 1'b0;
			mem_ready           <= 1'b1;
			mem_read_data_valid <= 1'b0;
		end else begin
			mem_read_data_valid <= 1'b0;
			if (rd_busy) begin
				if (rd_wait == 0) begin
					mem_read_data       <= mem[rd_addr[11:2]];
					mem_read_data_valid <= 1'b1;
					rd_busy = 1'b0;
				end else
					rd_wait--;
			end
			if (mem_access && mem_ready) begin
				if (!first_seen) begin
					first_seen = 1'b1;
					first_wr   = mem_rd0_wr1;
					first_addr = mem_addr;
				end
				if (mem_rd0_wr1) begin
					mem[mem_addr[11:2]] = mem_write_data;
					wr_addr_q.push_back(mem_addr);
					wr_data_q.push_back(mem_write_data);
				end else begin
					rd_busy = 1'b1;
					rd_addr = mem_addr;
					rd_wait = lat_en ? ($random(seed) & 3) : 0;  // extra cycles
				end
			end
			mem_ready <= lat_en ? (($random(seed) & 3) != 0) : 1'b1;
		end
	end

	always @(posedge cpu_clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT)
			abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
		else if (u_dut.u_asserts.fails != 0)
			abort_run("a memory bus protocol assertion failed");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			abort_run($sformatf("error: %s expected %h got %h", name, exp, got));
	endtask

	task automatic compare_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			abort_run($sformatf("error: %s expected %h got %h", name, exp, got));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("error: %s expected %h got %h", name, exp, got));
	endtask

	// RV32I encodings
	function automatic data_t r_word(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic data_t i_word(int opc, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic data_t s_word(int rs1, int rs2, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic data_t b_word(int f3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic data_t u_word(int rd, int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic data_t sext12(int imm);
		return {{20{imm[11]}}, imm[11:0]};
	endfunction

	task automatic clear_image(input addr_t start);
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = 32'h5a5a_0000 ^ (32'(i) << 2);
		prog_pc = start;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic emit(input data_t w);
		image[prog_pc[11:2]] = w;
		prog_pc = prog_pc + 32'd4;
	endtask

	task automatic expect_write(input addr_t a, input data_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic reset_core(input addr_t start, input bit slow);
		@(posedge cpu_clk);
		arst_n    <= 1'b0;
		boot_addr <= start;
		lat_en    <= slow;
		repeat (10) @(posedge cpu_clk);
		arst_n <= 1'b1;
	endtask

	task automatic check_writes;
		int n;
		n = exp_addr.size();
		while (wr_addr_q.size() < n)
			@(posedge cpu_clk);
		repeat (40) @(negedge cpu_clk);  // a wrong-path store would show up here
		if (wr_addr_q.size() != n)
			abort_run("more memory writes than the program should make");
		for (int k = 0; k < n; k++) begin
			compare_addr("mem_addr", wr_addr_q[k], exp_addr[k]);
			compare_data("mem_write_data", wr_data_q[k], exp_data[k]);
		end
	endtask

	task automatic boot_fetch;
		clear_image(BOOT_ALT);
		emit(b_word(0, 0, 0, 0));    // beq x0,x0,0
		reset_core(BOOT_ALT, 1'b0);
		@(posedge cpu_clk);
		compare_bit("mem_access", mem_access, 1'b0);
		while (!first_seen)
			@(posedge cpu_clk);
		compare_bit("mem_rd0_wr1", first_wr, 1'b0);
		compare_addr("mem_addr", first_addr, BOOT_ALT);
	endtask

	task automatic alu_ops;
		data_t r [1:11];
		clear_image(BOOT);
		r[1]  = {20'h12345, 12'h000};
		r[2]  = r[1] + sext12('h678);
		r[3]  = 32'h0 + sext12(-5);
		r[4]  = r[2] & sext12('h0f0);
		r[5]  = r[2] | sext12(-256);
		r[6]  = r[3] ^ sext12('h7ff);
		r[7]  = r[2] + r[3];
		r[8]  = r[2] - r[3];
		r[9]  = r[2] & r[6];
		r[10] = r[4] | r[1];
		r[11] = r[2] ^ r[5];
		emit(u_word(1, 'h12345));
		emit(i_word('h13, 0, 2, 1, 'h678));     // addi
		emit(i_word('h13, 0, 3, 0, -5));
		emit(i_word('h13, 7, 4, 2, 'h0f0));     // andi
		emit(i_word('h13, 6, 5, 2, -256));      // ori
		emit(i_word('h13, 4, 6, 3, 'h7ff));     // xori
		emit(r_word('h00, 0, 7, 2, 3));         // add
		emit(r_word('h20, 0, 8, 2, 3));         // sub
		emit(r_word('h00, 7, 9, 2, 6));
		emit(r_word('h00, 6, 10, 4, 1));
		emit(r_word('h00, 4, 11, 2, 5));
		emit(i_word('h13, 0, 12, 0, 'h600));    // store base
		for (int k = 1; k <= 11; k++) begin
			emit(s_word(12, k, 4 * (k - 1)));
			expect_write(32'h600 + 4 * (k - 1), r[k]);
		end
		emit(b_word(0, 0, 0, 0));
		reset_core(BOOT, 1'b0);
		check_writes();
	endtask

	// loaded word used at once by an add and both stored
	task automatic load_use(input bit slow);
		data_t word;
		word = 32'h1357_9bdf;
		clear_image(BOOT);
		image[32'h700 >> 2] = word;
		emit(i_word('h13, 0, 1, 0, 'h700));
		emit(i_word('h13, 0, 3, 0, 'h123));
		emit(i_word('h03, 2, 2, 1, 0));         // lw x2,0(x1)
		emit(r_word('h00, 0, 4, 2, 3));
		emit(s_word(1, 4, 8));
		emit(s_word(1, 2, 12));
		emit(b_word(0, 0, 0, 0));
		expect_write(32'h708, word + sext12('h123));
		expect_write(32'h70c, word);
		reset_core(BOOT, slow);
		check_writes();
	endtask

	task automatic branch_skips;
		clear_image(BOOT);
		emit(i_word('h13, 0, 1, 0, 5));
		emit(i_word('h13, 0, 2, 0, 5));
		emit(i_word('h13, 0, 3, 0, 'h600));
		emit(b_word(0, 1, 2, 8));       // beq taken
		emit(s_word(3, 1, 0));
		emit(s_word(3, 2, 4));
		emit(b_word(1, 1, 0, 8));       // bne taken
		emit(s_word(3, 1, 8));
		emit(b_word(1, 1, 2, 8));       // bne not taken
		emit(s_word(3, 1, 12));
		emit(b_word(0, 1, 0, 8));       // beq not taken
		emit(s_word(3, 3, 16));
		emit(b_word(0, 0, 0, 0));
		expect_write(32'h604, 32'd5);
		expect_write(32'h60c, 32'd5);
		expect_write(32'h610, 32'h600);
		reset_core(BOOT, 1'b0);
		check_writes();
	endtask

	initial begin
		seed      = 32'hf3378892;
		arst_n    = 1'b0;
		boot_addr = BOOT;
		lat_en    = 1'b0;
		boot_fetch();
		alu_ops();
		load_use(1'b0);
		branch_skips();
		load_use(1'b1);
		if (u_dut.u_asserts.fails != 0) begin
			abort_run("a memory bus protocol assertion failed");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

//--- rtl/alu.sv
/* ALU operations, branch equality compare and branch target adder */
`timescale 1ns/100ps

module alu import core_pkg::*; (
	input  data_t   alu_a,
	input  data_t   alu_b,
	input  alu_op_e alu_op,
	input  logic    is_branch,
	input  logic    branch_ne,
	input  addr_t   pc,
	input  data_t   br_imm,
	output data_t   alu_result,
	output logic    branch_taken,
	output addr_t   branch_target
);

	logic equal;

	// add also forms the load/store address
	always_comb begin
		case (alu_op)
			ALU_ADD:    alu_result = alu_a + alu_b;
			ALU_SUB:    alu_result = alu_a - alu_b;
			ALU_AND:    alu_result = alu_a & alu_b;
			ALU_OR:     alu_result = alu_a | alu_b;
			ALU_XOR:    alu_result = alu_a ^ alu_b;
			ALU_PASS_B: alu_result = alu_b;     // lui
			default:    alu_result = alu_a + alu_b;
		endcase
	end

	assign equal = alu_a == alu_b;

	// beq on equal, bne on not equal
	assign branch_taken  = is_branch && (equal ^ branch_ne);
	assign branch_target = pc + br_imm;

endmodule

//--- rtl/core.sv
/* core top: fetch, decoder, ALU, data controller and the memory arbiter */
`timescale 1ns/100ps

module core import core_pkg::*; (
	input  logic  cpu_clk,
	input  logic  arst_n,
	input  addr_t boot_addr,
	output logic  mem_access,
	output logic  mem_rd0_wr1,      // 0 read, 1 write
	output addr_t mem_addr,
	output data_t mem_write_data,
	input  logic  mem_ready,
	input  data_t mem_read_data,
	input  logic  mem_read_data_valid
);

	logic    instr_valid, instr_taken;
	instr_u  instr;
	addr_t   instr_pc;
	logic    redirect;
	addr_t   redirect_pc;
	logic    fetch_req, fetch_grant, fetch_data_valid;
	addr_t   fetch_addr;
	data_t   fetch_data;
	data_t   alu_a, alu_b, br_imm, alu_result;
	alu_op_e alu_op;
	logic    is_branch, branch_ne, branch_taken;
	addr_t   branch_target;
	logic    ls_start, ls_load, ls_done;
	addr_t   ls_addr;
	data_t   ls_wdata, load_data;
	logic    data_req, data_wr, data_grant, data_rdata_valid;
	addr_t   data_addr;
	data_t   data_wdata, data_rdata;

	fetch u_fetch (.*);

	dec u_dec (.*);

	alu u_alu (
		.alu_a         (alu_a),
		.alu_b         (alu_b),
		.alu_op        (alu_op),
		.is_branch     (is_branch),
		.branch_ne     (branch_ne),
		.pc            (instr_pc),
		.br_imm        (br_imm),
		.alu_result    (alu_result),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	dmem_ctrl u_dmem_ctrl (.*);

	mem_arbiter u_mem_arbiter (.*);

endmodule

//--- rtl/core_pkg.sv
/* shared widths, RV32I opcode and funct3/funct7 constants,
   the two-view instruction word and the ALU operation codes */
package core_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	typedef logic [XLEN-1:0]   addr_t;
	typedef logic [XLEN-1:0]   data_t;
	typedef logic [REG_AW-1:0] reg_idx_t;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR  = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010; // word size, LW and SW alike

	localparam logic [6:0] F7_SUB = 7'b0100000;

	// one instruction word, seen as R layout or S/B layout
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [6:0] imm_hi;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	localparam instr_u NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

endpackage

//--- rtl/dec.sv
/* decoder, general register file, operand select, write-back
   and the idle / memory-wait sequencer */
`timescale 1ns/100ps

module dec import core_pkg::*; (
	input  logic    cpu_clk,
	input  logic    arst_n,
	input  logic    instr_valid,
	input  instr_u  instr,
	input  addr_t   instr_pc,
	output logic    instr_taken,
	output data_t   alu_a,
	output data_t   alu_b,
	output alu_op_e alu_op,
	output logic    is_branch,
	output logic    branch_ne,
	output data_t   br_imm,
	input  data_t   alu_result,
	input  logic    branch_taken,
	input  addr_t   branch_target,
	output logic    redirect,
	output addr_t   redirect_pc,
	output logic    ls_start,
	output logic    ls_load,
	output addr_t   ls_addr,
	output data_t   ls_wdata,
	input  logic    ls_done,
	input  data_t   load_data
);

	data_t    regs [31:1];  // x0 is not stored
	data_t    rs1_val, rs2_val;
	data_t    imm_i, imm_s, imm_u;
	logic     is_lui, is_opimm, is_op, is_load, is_store, is_alu;
	alu_op_e  f3_op;
	logic     wait_mem;     // sequencer state, high while a load/store runs
	logic     ld_pend;
	reg_idx_t ld_rd;

	assign is_lui   = instr.r.opcode == OPC_LUI;
	assign is_opimm = instr.r.opcode == OPC_OP_IMM;
	assign is_op    = instr.r.opcode == OPC_OP;
	assign is_load  = instr.r.opcode == OPC_LOAD && instr.r.funct3 == F3_LW;
	assign is_store = instr.s.opcode == OPC_STORE && instr.s.funct3 == F3_LW;
	assign is_alu   = is_lui || is_opimm || is_op;
	assign is_branch = instr.s.opcode == OPC_BRANCH &&
		(instr.s.funct3 == F3_BEQ || instr.s.funct3 == F3_BNE);
	assign branch_ne = instr.s.funct3 == F3_BNE;

	// immediates, I and U from the r view, S and B from the s view
	assign imm_i  = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
	assign imm_u  = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
	assign imm_s  = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	assign br_imm = {{19{instr.s.imm_hi[6]}}, instr.s.imm_hi[6], instr.s.imm_lo[0],
		instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};

	assign rs1_val = (instr.r.rs1 == '0) ? '0 : regs[instr.r.rs1];
	assign rs2_val = (instr.r.rs2 == '0) ? '0 : regs[instr.r.rs2];
	assign alu_a   = rs1_val;

	always_comb begin
		case (instr.r.funct3)
			F3_XOR:  f3_op = ALU_XOR;
			F3_OR:   f3_op = ALU_OR;
			F3_AND:  f3_op = ALU_AND;
			default: f3_op = (is_op && instr.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
		endcase
	end

	always_comb begin
		alu_op = ALU_ADD;      // load/store address
		alu_b  = imm_i;
		if (is_lui) begin
			alu_op = ALU_PASS_B;
			alu_b  = imm_u;
		end else if (is_store) begin
			alu_b = imm_s;
		end else if (is_branch) begin
			alu_op = ALU_SUB;
			alu_b  = rs2_val;
		end else if (is_op) begin
			alu_op = f3_op;
			alu_b  = rs2_val;
		end else if (is_opimm) begin
			alu_op = f3_op;
		end
	end

	assign instr_taken = instr_valid && !wait_mem;
	assign ls_start    = instr_taken && (is_load || is_store);
	assign ls_load     = is_load;
	assign ls_addr     = alu_result;
	assign ls_wdata    = rs2_val;

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			wait_mem <= 1'b0;
			ld_pend  <= 1'b0;
			redirect <= 1'b0;
		end else begin
			redirect <= instr_taken && branch_taken;
			if (ls_start) begin
				wait_mem <= 1'b1;
				ld_pend  <= is_load;
			end else if (ls_done) begin
				wait_mem <= 1'b0;
				ld_pend  <= 1'b0;
			end
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (instr_taken && branch_taken)
			redirect_pc <= branch_target;
		if (ls_start)
			ld_rd <= instr.r.rd;
		if (instr_taken && is_alu && instr.r.rd != '0)
			regs[instr.r.rd] <= alu_result;
		else if (ls_done && ld_pend && ld_rd != '0)
			regs[ld_rd] <= load_data;    // load write-back
	end

endmodule

//--- rtl/dmem_ctrl.sv
/* data memory controller: word load/store request, wait for grant
   or read data, completion pulse */
`timescale 1ns/100ps

module dmem_ctrl import core_pkg::*; (
	input  logic  cpu_clk,
	input  logic  arst_n,
	input  logic  ls_start,
	input  logic  ls_load,
	input  addr_t ls_addr,
	input  data_t ls_wdata,
	output logic  ls_done,
	output data_t load_data,
	output logic  data_req,
	output logic  data_wr,
	output addr_t data_addr,
	output data_t data_wdata,
	input  logic  data_grant,
	input  data_t data_rdata,
	input  logic  data_rdata_valid
);

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			data_req <= 1'b0;
			data_wr  <= 1'b0;
			ls_done  <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			if (ls_start) begin
				data_req <= 1'b1;
				data_wr  <= !ls_load;
			end
			if (data_grant) begin
				data_req <= 1'b0;
				ls_done  <= data_wr;  // store is done once accepted
			end
			if (data_rdata_valid)
				ls_done <= 1'b1;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (ls_start) begin
			data_addr  <= ls_addr;
			data_wdata <= ls_wdata;
		end
		if (data_rdata_valid)
			load_data <= data_rdata;
	end

endmodule

//--- rtl/fetch.sv
/* program counter, one-word instruction register and prefetch,
   stale response drop after a taken branch */
`timescale 1ns/100ps

module fetch import core_pkg::*; (
	input  logic   cpu_clk,
	input  logic   arst_n,
	input  addr_t  boot_addr,
	input  logic   instr_taken,
	input  logic   redirect,
	input  addr_t  redirect_pc,
	output logic   fetch_req,
	output addr_t  fetch_addr,
	input  logic   fetch_grant,
	input  data_t  fetch_data,
	input  logic   fetch_data_valid,
	output logic   instr_valid,
	output instr_u instr,
	output addr_t  instr_pc
);

	addr_t pc;       // next address to fetch once the bus side is quiet
	logic  rd_pend;  // granted, data not back yet
	logic  drop;     // outstanding word is from the old path

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= boot_addr;
			fetch_addr  <= boot_addr;
			fetch_req   <= 1'b0;
			rd_pend     <= 1'b0;
			drop        <= 1'b0;
			instr_valid <= 1'b0;
			instr       <= NOP_INSTR;
		end else begin
			if (fetch_grant) begin
				fetch_req <= 1'b0;
				rd_pend   <= 1'b1;
			end
			if (fetch_data_valid) begin
				rd_pend     <= 1'b0;
				drop        <= 1'b0;
				instr_valid <= !drop;
				if (!drop)
					instr <= fetch_data;
			end
			if (instr_taken) begin
				// register emptied, prefetch the next word right away
				instr_valid <= 1'b0;
				fetch_req   <= 1'b1;
				fetch_addr  <= instr_pc + 32'd4;
				pc          <= instr_pc + 32'd4;
			end else if (redirect) begin
				pc <= redirect_pc;
				if (fetch_req || rd_pend) begin
					drop <= 1'b1;          // let the old access finish first
				end else begin
					fetch_req  <= 1'b1;
					fetch_addr <= redirect_pc;
				end
			end else if (!instr_valid && !fetch_req && !rd_pend) begin
				fetch_req  <= 1'b1;        // boot, or target after a drop
				fetch_addr <= pc;
			end
		end
	end

	// address of the word in the register
	always_ff @(posedge cpu_clk) begin
		if (fetch_data_valid && !drop)
			instr_pc <= fetch_addr;
	end

endmodule

//--- rtl/mem_arbiter.sv
/* single memory port arbiter, data before fetch, owner held until
   write accept or read data return */
`timescale 1ns/100ps

module mem_arbiter import core_pkg::*; (
	input  logic  cpu_clk,
	input  logic  arst_n,
	input  logic  fetch_req,
	input  addr_t fetch_addr,
	output logic  fetch_grant,
	output data_t fetch_data,
	output logic  fetch_data_valid,
	input  logic  data_req,
	input  logic  data_wr,
	input  addr_t data_addr,
	input  data_t data_wdata,
	output logic  data_grant,
	output data_t data_rdata,
	output logic  data_rdata_valid,
	output logic  mem_access,
	output logic  mem_rd0_wr1,
	output addr_t mem_addr,
	output data_t mem_write_data,
	input  logic  mem_ready,
	input  data_t mem_read_data,
	input  logic  mem_read_data_valid
);

	logic own_data;  // current owner, 1 for data
	logic locked;    // request on the bus, not accepted yet
	logic rd_pend;   // read accepted, waiting for valid
	logic sel_data;
	logic accept;

	assign sel_data       = (locked || rd_pend) ? own_data : data_req;
	assign mem_access     = !rd_pend && (sel_data ? data_req : fetch_req);
	assign mem_rd0_wr1    = sel_data && data_wr;
	assign mem_addr       = sel_data ? data_addr : fetch_addr;
	assign mem_write_data = data_wdata;
	assign accept         = mem_access && mem_ready;

	assign data_grant  = accept && sel_data;
	assign fetch_grant = accept && !sel_data;

	// read data is shared, valid only goes to the owner
	assign fetch_data       = mem_read_data;
	assign data_rdata       = mem_read_data;
	assign fetch_data_valid = mem_read_data_valid && rd_pend && !own_data;
	assign data_rdata_valid = mem_read_data_valid && rd_pend && own_data;

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			own_data <= 1'b0;
			locked   <= 1'b0;
			rd_pend  <= 1'b0;
		end else begin
			if (mem_read_data_valid)
				rd_pend <= 1'b0;
			if (mem_access) begin
				own_data <= sel_data;
				locked   <= !mem_ready;
				if (mem_ready && !mem_rd0_wr1)
					rd_pend <= 1'b1;
			end
		end
	end

endmodule
